// File: mips_mem.f
rtl/mips_pkg.sv
rtl/data_ram.sv
rtl/mem_access.sv
rtl/mem_wb_reg.sv
rtl/cp0_regs.sv
rtl/mem_stage_top.sv
verification/tb_clk_gen.sv
verification/tb_mem_stage.sv

// File: verification/tb_mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_stage;
	import mips_pkg::*;

	localparam int num_instr  = 2000;
	localparam int preload_n  = 64;
	localparam int max_cycles = 8 + num_instr + 100;

	logic        clk;
	logic        rst_n;
	logic [5:0]  int_lines;
	aluop_e      aluop;
	logic [4:0]  wd;
	logic        wreg;
	logic [31:0] wdata;
	logic [31:0] hi;
	logic [31:0] lo;
	logic        whilo;
	logic [31:0] mem_addr;
	logic [31:0] reg2;
	logic        cp0_we;
	logic [4:0]  cp0_waddr;
	logic [31:0] cp0_wdata;
	logic [31:0] excepttype;
	logic        in_delay;
	logic [31:0] inst_addr;

	logic [4:0]  wb_wd;
	logic        wb_wreg;
	logic [31:0] wb_wdata;
	logic [31:0] wb_hi;
	logic [31:0] wb_lo;
	logic        wb_whilo;
	logic        wb_cp0_we;
	logic [4:0]  wb_cp0_waddr;
	logic [31:0] wb_cp0_wdata;
	logic        exc_valid;
	exc_code_e   exc_code;
	logic [31:0] cp0_epc;
	logic [31:0] cp0_status;

	// model RAM of the first 64 words with byte 0 in the msb lane
	logic [7:0]  mbyte [256];
	logic [31:0] m_status;
	logic [31:0] m_cause;
	logic [31:0] m_epc;
	logic        pend_we;	// CP0 write sitting in writeback
	logic [4:0]  pend_addr;
	logic [31:0] pend_data;

	logic [4:0]  exp_wd;
	logic        exp_wreg;
	logic [31:0] exp_wdata;
	logic [31:0] exp_hi;
	logic [31:0] exp_lo;
	logic        exp_whilo;
	logic        exp_cp0_we;
	logic [4:0]  exp_cp0_waddr;
	logic [31:0] exp_cp0_wdata;

	int seed;
	int n_checks;
	int n_errors;
	int cycles;

	// priority order after the interrupt
	int     exc_bits [11] = '{1, 2, 3, 4, 5, 8, 10, 11, 12, 23, 14};
	aluop_e op_tab [14]   = '{aluop_nop, aluop_lb, aluop_lbu, aluop_lh, aluop_lhu, aluop_lw,
		aluop_lwl, aluop_lwr, aluop_sb, aluop_sh, aluop_sw, aluop_swl, aluop_swr, aluop_mtc0};

	tb_clk_gen i_clk_gen (
		.clk_o(clk), .rst_n_o(rst_n)
	);

	mem_stage_top #(
		.RAM_ADDR_W(10)
	) i_mem_stage_top (
		.clk_i(clk), .rst_n_i(rst_n), .int_i(int_lines), .aluop_i(aluop),
		.wd_i(wd), .wreg_i(wreg), .wdata_i(wdata), .hi_i(hi), .lo_i(lo), .whilo_i(whilo),
		.mem_addr_i(mem_addr), .reg2_i(reg2),
		.cp0_we_i(cp0_we), .cp0_waddr_i(cp0_waddr), .cp0_wdata_i(cp0_wdata),
		.excepttype_i(excepttype), .is_in_delayslot_i(in_delay),
		.current_inst_address_i(inst_addr),
		.wb_wd_o(wb_wd), .wb_wreg_o(wb_wreg), .wb_wdata_o(wb_wdata),
		.wb_hi_o(wb_hi), .wb_lo_o(wb_lo), .wb_whilo_o(wb_whilo),
		.wb_cp0_we_o(wb_cp0_we), .wb_cp0_waddr_o(wb_cp0_waddr), .wb_cp0_wdata_o(wb_cp0_wdata),
		.exc_valid_o(exc_valid), .exc_code_o(exc_code),
		.cp0_epc_o(cp0_epc), .cp0_status_o(cp0_status)
	);

	function automatic logic [31:0] ram_word(input logic [31:0] addr);
		logic [7:0] a;
		a = {addr[7:2], 2'b00};
		return {mbyte[a], mbyte[a+1], mbyte[a+2], mbyte[a+3]};
	endfunction

	// register value after the load or pass for anything else
	function automatic logic [31:0] load_value(input aluop_e op, input logic [31:0] addr,
			input logic [31:0] r2, input logic [31:0] w, input logic [31:0] pass);
		logic [1:0]  b;
		logic [7:0]  by;
		logic [15:0] hw;
		logic [31:0] res;
		b   = addr[1:0];
		by  = w[31-8*b -: 8];
		hw  = w[31-8*{b[1], 1'b0} -: 16];	// halfword starting at the even byte
		res = r2;
		case (op)
			aluop_lb:  res = {{24{by[7]}}, by};
			aluop_lbu: res = {24'd0, by};
			aluop_lh:  res = b[0] ? 32'd0 : {{16{hw[15]}}, hw};
			aluop_lhu: res = b[0] ? 32'd0 : {16'd0, hw};
			aluop_lw:  res = w;
			aluop_lwl: begin
				for (int i = 0; i <= 3 - b; i++) begin
					res[31-8*i -: 8] = w[31-8*(b+i) -: 8];
				end
			end
			aluop_lwr: begin
				for (int i = 0; i <= b; i++) begin
					res[31-8*(3-b+i) -: 8] = w[31-8*i -: 8];
				end
			end
			default:   res = pass;
		endcase
		return res;
	endfunction

	task automatic store_bytes(input aluop_e op, input logic [31:0] addr, input logic [31:0] r2);
		logic [7:0] a;
		logic [1:0] b;
		a = {addr[7:2], 2'b00};
		b = addr[1:0];
		case (op)
			aluop_sb: mbyte[a+b] = r2[7:0];
			aluop_sh: begin
				if (!b[0]) begin
					mbyte[a+b]   = r2[15:8];
					mbyte[a+b+1] = r2[7:0];
				end
			end
			aluop_sw, aluop_swl: begin	// sw is always aligned here
				for (int i = 0; i <= 3 - b; i++) begin
					mbyte[a+b+i] = r2[31-8*i -: 8];
				end
			end
			aluop_swr: begin
				for (int i = 0; i <= b; i++) begin
					mbyte[a+i] = r2[31-8*(3-b+i) -: 8];
				end
			end
			default: begin
			end
		endcase
	endtask

	task automatic compare_word(input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		n_checks++;
		if (act_v !== exp_v) begin
			n_errors++;
			$display("mismatch at %0t ns: %s expected %h actual %h", $time, name, exp_v, act_v);
		end
	endtask

	task automatic issue(input int n);
		logic [31:0] r0;
		logic [31:0] r1;
		logic [31:0] r2;
		aluop_e      op;
		logic [31:0] ad;
		logic [31:0] et;
		r0 = $random(seed);
		r1 = $random(seed);
		r2 = $random(seed);
		op = op_tab[r0[15:0] % 14];
		ad = {24'd0, r0[23:16]};
		et = '0;
		if (r0[26:24] == 3'd0) begin
			et[exc_bits[r1[15:0] % 11]] = 1'b1;
		end
		if (r0[30:27] == 4'd0) begin
			et[exc_bits[r1[31:16] % 11]] = 1'b1;	// second cause so priority decides
		end
		if (n < preload_n) begin
			op = aluop_sw;	// fill the low words first
			ad = n * 4;
			et = '0;
		end
		if (op == aluop_lw || op == aluop_sw) begin
			ad[1:0] = 2'b00;
		end
		aluop      <= op;
		mem_addr   <= ad;
		excepttype <= et;
		wd         <= r2[4:0];
		wreg       <= r2[5];
		whilo      <= r2[6];
		in_delay   <= r2[7];
		int_lines  <= (r2[9:8] == 2'd0) ? r2[15:10] : 6'd0;
		cp0_we     <= (op == aluop_mtc0);
		cp0_waddr  <= (op == aluop_mtc0) ? 5'd12 + r2[17:16] % 3 : r2[20:16];
		inst_addr  <= (r2[31:28] == 4'd0) ? 32'd0 : {r1[31:2], 2'b00} | 32'h100;
		reg2       <= $random(seed);
		wdata      <= $random(seed);
		hi         <= $random(seed);
		lo         <= $random(seed);
		cp0_wdata  <= $random(seed);
	endtask

	task automatic check_and_update();
		logic [31:0] f_status;
		logic [31:0] f_cause;
		logic [31:0] f_epc;
		logic        exc;
		logic [4:0]  code;
		logic        old_exl;
		// previous instruction in writeback
		compare_word("wb_wd_o", exp_wd, wb_wd);
		compare_word("wb_wreg_o", exp_wreg, wb_wreg);
		compare_word("wb_wdata_o", exp_wdata, wb_wdata);
		compare_word("wb_hi_o", exp_hi, wb_hi);
		compare_word("wb_lo_o", exp_lo, wb_lo);
		compare_word("wb_whilo_o", exp_whilo, wb_whilo);
		compare_word("wb_cp0_we_o", exp_cp0_we, wb_cp0_we);
		compare_word("wb_cp0_waddr_o", exp_cp0_waddr, wb_cp0_waddr);
		compare_word("wb_cp0_wdata_o", exp_cp0_wdata, wb_cp0_wdata);
		compare_word("cp0_status_o", m_status, cp0_status);

		f_status = m_status;
		f_cause  = m_cause;
		f_epc    = m_epc;
		if (pend_we) begin
			case (pend_addr)
				cp0_status_addr: f_status = pend_data;
				cp0_epc_addr:    f_epc = pend_data;
				cp0_cause_addr: begin
					f_cause[9:8]   = pend_data[9:8];
					f_cause[23:22] = pend_data[23:22];
				end
				default: begin
				end
			endcase
		end

		exc  = 1'b0;
		code = 5'd0;
		if (inst_addr != 32'd0) begin
			if ((|(f_cause[15:8] & f_status[15:8])) && f_status[0] && !f_status[1]) begin
				exc = 1'b1;	// interrupt
			end
			for (int i = 0; i < 11; i++) begin
				if (!exc && excepttype[exc_bits[i]]) begin
					exc  = 1'b1;
					code = exc_bits[i];	// codes equal the bit numbers
				end
			end
		end
		compare_word("exc_valid_o", exc, exc_valid);
		if (exc) begin
			compare_word("exc_code_o", code, exc_code);
		end
		compare_word("cp0_epc_o", f_epc, cp0_epc);

		exp_wd        = wd;
		exp_wreg      = wreg & !exc;
		exp_wdata     = load_value(aluop, mem_addr, reg2, ram_word(mem_addr), wdata);
		exp_hi        = hi;
		exp_lo        = lo;
		exp_whilo     = whilo & !exc;
		exp_cp0_we    = cp0_we & !exc;
		exp_cp0_waddr = cp0_waddr;
		exp_cp0_wdata = cp0_wdata;

		// state after the coming edge
		if (!exc) begin
			store_bytes(aluop, mem_addr, reg2);
		end
		old_exl        = m_status[1];
		m_status       = f_status;
		m_cause        = f_cause;
		m_epc          = f_epc;
		m_cause[15:10] = int_lines;
		if (exc && code == 5'd14) begin
			m_status[1] = 1'b0;	// eret
		end else if (exc) begin
			if (!old_exl) begin
				m_epc       = in_delay ? inst_addr - 32'd4 : inst_addr;
				m_cause[31] = in_delay;
			end
			m_status[1]  = 1'b1;
			m_cause[6:2] = code;
		end
		pend_we   = exp_cp0_we;
		pend_addr = cp0_waddr;
		pend_data = cp0_wdata;
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("timeout, run stopped after %0d cycles", cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial begin
		seed       = 32'hdfb2f744;
		n_checks   = 0;
		n_errors   = 0;
		cycles     = 0;
		int_lines  = '0;
		aluop      = aluop_nop;
		wd         = '0;
		wreg       = 1'b0;
		wdata      = '0;
		hi         = '0;
		lo         = '0;
		whilo      = 1'b0;
		mem_addr   = '0;
		reg2       = '0;
		cp0_we     = 1'b0;
		cp0_waddr  = '0;
		cp0_wdata  = '0;
		excepttype = '0;
		in_delay   = 1'b0;
		inst_addr  = '0;
		m_status   = '0;
		m_cause    = '0;
		m_epc      = '0;
		pend_we    = 1'b0;
		pend_addr  = '0;
		pend_data  = '0;
		exp_wd        = '0;
		exp_wreg      = 1'b0;
		exp_wdata     = '0;
		exp_hi        = '0;
		exp_lo        = '0;
		exp_whilo     = 1'b0;
		exp_cp0_we    = 1'b0;
		exp_cp0_waddr = '0;
		exp_cp0_wdata = '0;

		wait (rst_n === 1'b1);
		for (int n = 0; n <= num_instr; n++) begin
			@(posedge clk);
			issue(n);
			@(negedge clk);	// outputs settled
			check_and_update();
		end

		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o   = 1'b0;
		rst_n_o = 1'b0;
		repeat (8) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;	// release away from the active edge
	end

	always #4 clk_o = ~clk_o;	// 8 ns period

endmodule

`default_nettype wire

// File: rtl/mem_stage_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage_top #(
	parameter int RAM_ADDR_W = 10
) (
	input  logic                            clk_i,
	input  logic                            rst_n_i,
	input  logic [5:0]                      int_i,
	input  mips_pkg::aluop_e                aluop_i,
	input  logic [mips_pkg::reg_addr_w-1:0] wd_i,
	input  logic                            wreg_i,
	input  logic [mips_pkg::word_w-1:0]     wdata_i,
	input  logic [mips_pkg::word_w-1:0]     hi_i,
	input  logic [mips_pkg::word_w-1:0]     lo_i,
	input  logic                            whilo_i,
	input  logic [mips_pkg::word_w-1:0]     mem_addr_i,
	input  logic [mips_pkg::word_w-1:0]     reg2_i,
	input  logic                            cp0_we_i,
	input  logic [4:0]                      cp0_waddr_i,
	input  logic [mips_pkg::word_w-1:0]     cp0_wdata_i,
	input  logic [31:0]                     excepttype_i,
	input  logic                            is_in_delayslot_i,
	input  logic [mips_pkg::word_w-1:0]     current_inst_address_i,
	output logic [mips_pkg::reg_addr_w-1:0] wb_wd_o,
	output logic                            wb_wreg_o,
	output logic [mips_pkg::word_w-1:0]     wb_wdata_o,
	output logic [mips_pkg::word_w-1:0]     wb_hi_o,
	output logic [mips_pkg::word_w-1:0]     wb_lo_o,
	output logic                            wb_whilo_o,
	output logic                            wb_cp0_we_o,
	output logic [4:0]                      wb_cp0_waddr_o,
	output logic [mips_pkg::word_w-1:0]     wb_cp0_wdata_o,
	output logic                            exc_valid_o,
	output mips_pkg::exc_code_e             exc_code_o,
	output logic [mips_pkg::word_w-1:0]     cp0_epc_o,
	output logic [mips_pkg::word_w-1:0]     cp0_status_o
);
	import mips_pkg::*;

	logic [reg_addr_w-1:0] ma_wd;
	logic                  ma_wreg;
	logic [word_w-1:0]     ma_wdata;
	logic [word_w-1:0]     ma_hi;
	logic [word_w-1:0]     ma_lo;
	logic                  ma_whilo;
	logic                  ma_cp0_we;
	logic [4:0]            ma_cp0_waddr;
	logic [word_w-1:0]     ma_cp0_wdata;
	logic                  ram_ce;
	logic                  ram_we;
	logic [3:0]            ram_sel;
	logic [word_w-1:0]     ram_addr;
	logic [word_w-1:0]     ram_wdata;
	logic [word_w-1:0]     ram_rdata;
	logic [word_w-1:0]     cp0_cause;
	logic [word_w-1:0]     cp0_epc;
	logic                  exc_delayslot;
	logic [word_w-1:0]     exc_inst_addr;

	mem_access i_mem_access (
		.rst_n_i(rst_n_i), .aluop_i(aluop_i),
		.wd_i(wd_i), .wreg_i(wreg_i), .wdata_i(wdata_i),
		.hi_i(hi_i), .lo_i(lo_i), .whilo_i(whilo_i),
		.mem_addr_i(mem_addr_i), .reg2_i(reg2_i),
		.cp0_we_i(cp0_we_i), .cp0_waddr_i(cp0_waddr_i), .cp0_wdata_i(cp0_wdata_i),
		.excepttype_i(excepttype_i), .is_in_delayslot_i(is_in_delayslot_i),
		.current_inst_address_i(current_inst_address_i),
		.mem_data_i(ram_rdata),
		.cp0_status_i(cp0_status_o), .cp0_cause_i(cp0_cause), .cp0_epc_i(cp0_epc),
		.wb_cp0_we_i(wb_cp0_we_o), .wb_cp0_waddr_i(wb_cp0_waddr_o),
		.wb_cp0_wdata_i(wb_cp0_wdata_o),
		.wd_o(ma_wd), .wreg_o(ma_wreg), .wdata_o(ma_wdata),
		.hi_o(ma_hi), .lo_o(ma_lo), .whilo_o(ma_whilo),
		.cp0_we_o(ma_cp0_we), .cp0_waddr_o(ma_cp0_waddr), .cp0_wdata_o(ma_cp0_wdata),
		.mem_ce_o(ram_ce), .mem_we_o(ram_we), .mem_sel_o(ram_sel),
		.mem_addr_o(ram_addr), .mem_data_o(ram_wdata),
		.exc_valid_o(exc_valid_o), .exc_code_o(exc_code_o), .cp0_epc_o(cp0_epc_o),
		.is_in_delayslot_o(exc_delayslot), .current_inst_address_o(exc_inst_addr)
	);

	data_ram #(
		.RAM_ADDR_W(RAM_ADDR_W)
	) i_data_ram (
		.clk_i(clk_i), .ce_i(ram_ce), .we_i(ram_we), .sel_i(ram_sel),
		.addr_i(ram_addr), .data_i(ram_wdata), .data_o(ram_rdata)
	);

	mem_wb_reg i_mem_wb_reg (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .exc_valid_i(exc_valid_o),
		.wd_i(ma_wd), .wreg_i(ma_wreg), .wdata_i(ma_wdata),
		.hi_i(ma_hi), .lo_i(ma_lo), .whilo_i(ma_whilo),
		.cp0_we_i(ma_cp0_we), .cp0_waddr_i(ma_cp0_waddr), .cp0_wdata_i(ma_cp0_wdata),
		.wb_wd_o(wb_wd_o), .wb_wreg_o(wb_wreg_o), .wb_wdata_o(wb_wdata_o),
		.wb_hi_o(wb_hi_o), .wb_lo_o(wb_lo_o), .wb_whilo_o(wb_whilo_o),
		.wb_cp0_we_o(wb_cp0_we_o), .wb_cp0_waddr_o(wb_cp0_waddr_o),
		.wb_cp0_wdata_o(wb_cp0_wdata_o)
	);

	cp0_regs i_cp0_regs (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .int_i(int_i),
		.wb_cp0_we_i(wb_cp0_we_o), .wb_cp0_waddr_i(wb_cp0_waddr_o),
		.wb_cp0_wdata_i(wb_cp0_wdata_o),
		.exc_valid_i(exc_valid_o), .exc_code_i(exc_code_o),
		.is_in_delayslot_i(exc_delayslot), .current_inst_address_i(exc_inst_addr),
		.status_o(cp0_status_o), .cause_o(cp0_cause), .epc_o(cp0_epc)
	);

endmodule

`default_nettype wire

// File: rtl/cp0_regs.sv
`timescale 1ns/1ns
`default_nettype none

module cp0_regs (
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	input  logic [5:0]                  int_i,
	input  logic                        wb_cp0_we_i,
	input  logic [4:0]                  wb_cp0_waddr_i,
	input  logic [mips_pkg::word_w-1:0] wb_cp0_wdata_i,
	input  logic                        exc_valid_i,
	input  mips_pkg::exc_code_e         exc_code_i,
	input  logic                        is_in_delayslot_i,
	input  logic [mips_pkg::word_w-1:0] current_inst_address_i,
	output logic [mips_pkg::word_w-1:0] status_o,
	output logic [mips_pkg::word_w-1:0] cause_o,
	output logic [mips_pkg::word_w-1:0] epc_o
);
	import mips_pkg::*;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			status_o <= '0;
			cause_o  <= '0;
			epc_o    <= '0;
		end else begin
			cause_o[15:10] <= int_i;	// IP7..2 follow the pins

			if (wb_cp0_we_i) begin
				case (wb_cp0_waddr_i)
					cp0_status_addr: status_o <= wb_cp0_wdata_i;
					cp0_epc_addr:    epc_o <= wb_cp0_wdata_i;
					cp0_cause_addr: begin
						cause_o[9:8]   <= wb_cp0_wdata_i[9:8];
						cause_o[23:22] <= wb_cp0_wdata_i[23:22];
					end
					default: begin
					end
				endcase
			end

			// later assignments override the writeback fields
			if (exc_valid_i) begin
				if (exc_code_i == exc_eret) begin
					status_o[1] <= 1'b0;
				end else begin
					if (!status_o[1]) begin
						// nested exceptions keep the first EPC
						epc_o <= is_in_delayslot_i ?
							current_inst_address_i - 32'd4 : current_inst_address_i;
						cause_o[31] <= is_in_delayslot_i;
					end
					status_o[1]  <= 1'b1;
					cause_o[6:2] <= exc_code_i;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/mem_wb_reg.sv
`timescale 1ns/1ns
`default_nettype none

module mem_wb_reg (
	input  logic                            clk_i,
	input  logic                            rst_n_i,
	input  logic                            exc_valid_i,
	input  logic [mips_pkg::reg_addr_w-1:0] wd_i,
	input  logic                            wreg_i,
	input  logic [mips_pkg::word_w-1:0]     wdata_i,
	input  logic [mips_pkg::word_w-1:0]     hi_i,
	input  logic [mips_pkg::word_w-1:0]     lo_i,
	input  logic                            whilo_i,
	input  logic                            cp0_we_i,
	input  logic [4:0]                      cp0_waddr_i,
	input  logic [mips_pkg::word_w-1:0]     cp0_wdata_i,
	output logic [mips_pkg::reg_addr_w-1:0] wb_wd_o,
	output logic                            wb_wreg_o,
	output logic [mips_pkg::word_w-1:0]     wb_wdata_o,
	output logic [mips_pkg::word_w-1:0]     wb_hi_o,
	output logic [mips_pkg::word_w-1:0]     wb_lo_o,
	output logic                            wb_whilo_o,
	output logic                            wb_cp0_we_o,
	output logic [4:0]                      wb_cp0_waddr_o,
	output logic [mips_pkg::word_w-1:0]     wb_cp0_wdata_o
);

	// write enables dropped for a faulting instruction
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wb_wreg_o   <= 1'b0;
			wb_whilo_o  <= 1'b0;
			wb_cp0_we_o <= 1'b0;
		end else begin
			wb_wreg_o   <= wreg_i & ~exc_valid_i;
			wb_whilo_o  <= whilo_i & ~exc_valid_i;
			wb_cp0_we_o <= cp0_we_i & ~exc_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		wb_wd_o        <= wd_i;
		wb_wdata_o     <= wdata_i;
		wb_hi_o        <= hi_i;
		wb_lo_o        <= lo_i;
		wb_cp0_waddr_o <= cp0_waddr_i;
		wb_cp0_wdata_o <= cp0_wdata_i;
	end

endmodule

`default_nettype wire

// File: rtl/mem_access.sv
`timescale 1ns/1ns
`default_nettype none

module mem_access (
	input  logic                              rst_n_i,
	input  mips_pkg::aluop_e                  aluop_i,
	input  logic [mips_pkg::reg_addr_w-1:0]   wd_i,
	input  logic                              wreg_i,
	input  logic [mips_pkg::word_w-1:0]       wdata_i,
	input  logic [mips_pkg::word_w-1:0]       hi_i,
	input  logic [mips_pkg::word_w-1:0]       lo_i,
	input  logic                              whilo_i,
	input  logic [mips_pkg::word_w-1:0]       mem_addr_i,
	input  logic [mips_pkg::word_w-1:0]       reg2_i,
	input  logic                              cp0_we_i,
	input  logic [4:0]                        cp0_waddr_i,
	input  logic [mips_pkg::word_w-1:0]       cp0_wdata_i,
	input  logic [31:0]                       excepttype_i,
	input  logic                              is_in_delayslot_i,
	input  logic [mips_pkg::word_w-1:0]       current_inst_address_i,
	input  logic [mips_pkg::word_w-1:0]       mem_data_i,
	input  logic [mips_pkg::word_w-1:0]       cp0_status_i,
	input  logic [mips_pkg::word_w-1:0]       cp0_cause_i,
	input  logic [mips_pkg::word_w-1:0]       cp0_epc_i,
	input  logic                              wb_cp0_we_i,
	input  logic [4:0]                        wb_cp0_waddr_i,
	input  logic [mips_pkg::word_w-1:0]       wb_cp0_wdata_i,
	output logic [mips_pkg::reg_addr_w-1:0]   wd_o,
	output logic                              wreg_o,
	output logic [mips_pkg::word_w-1:0]       wdata_o,
	output logic [mips_pkg::word_w-1:0]       hi_o,
	output logic [mips_pkg::word_w-1:0]       lo_o,
	output logic                              whilo_o,
	output logic                              cp0_we_o,
	output logic [4:0]                        cp0_waddr_o,
	output logic [mips_pkg::word_w-1:0]       cp0_wdata_o,
	output logic                              mem_ce_o,
	output logic                              mem_we_o,
	output logic [3:0]                        mem_sel_o,
	output logic [mips_pkg::word_w-1:0]       mem_addr_o,
	output logic [mips_pkg::word_w-1:0]       mem_data_o,
	output logic                              exc_valid_o,
	output mips_pkg::exc_code_e               exc_code_o,
	output logic [mips_pkg::word_w-1:0]       cp0_epc_o,
	output logic                              is_in_delayslot_o,
	output logic [mips_pkg::word_w-1:0]       current_inst_address_o
);
	import mips_pkg::*;

	logic [1:0]        ofs;
	logic [4:0]        sh_l;
	logic [4:0]        sh_r;
	logic [7:0]        ld_byte;
	logic [15:0]       ld_half;
	logic              mem_ce;
	logic              mem_we;
	logic              exc_hit;
	exc_code_e         exc_sel;
	logic [word_w-1:0] status_fwd;
	logic [word_w-1:0] cause_fwd;
	logic [word_w-1:0] epc_fwd;

	assign wd_o        = wd_i;
	assign wreg_o      = wreg_i;
	assign hi_o        = hi_i;
	assign lo_o        = lo_i;
	assign whilo_o     = whilo_i;
	assign cp0_we_o    = cp0_we_i;
	assign cp0_waddr_o = cp0_waddr_i;
	assign cp0_wdata_o = cp0_wdata_i;

	assign is_in_delayslot_o      = is_in_delayslot_i;
	assign current_inst_address_o = current_inst_address_i;
	assign cp0_epc_o              = epc_fwd;

	// big endian, byte 0 sits in bits 31..24
	assign ofs     = mem_addr_i[1:0];
	assign sh_l    = {ofs, 3'b000};
	assign sh_r    = {~ofs, 3'b000};	// 8*(3-ofs)
	assign ld_byte = mem_data_i[sh_r +: 8];
	assign ld_half = ofs[1] ? mem_data_i[15:0] : mem_data_i[31:16];

	always_comb begin
		wdata_o    = wdata_i;
		mem_addr_o = '0;
		mem_data_o = '0;
		mem_sel_o  = 4'b0000;
		mem_ce     = 1'b0;
		mem_we     = 1'b0;
		case (aluop_i)
			aluop_lb, aluop_lbu: begin
				mem_ce     = 1'b1;
				mem_addr_o = mem_addr_i;
				mem_sel_o  = 4'b1000 >> ofs;
				wdata_o    = {{24{ld_byte[7] & (aluop_i == aluop_lb)}}, ld_byte};
			end
			aluop_lh, aluop_lhu: begin
				mem_ce     = 1'b1;
				mem_addr_o = mem_addr_i;
				if (ofs[0]) begin
					wdata_o = '0;	// misaligned half
				end else begin
					mem_sel_o = ofs[1] ? 4'b0011 : 4'b1100;
					wdata_o   = {{16{ld_half[15] & (aluop_i == aluop_lh)}}, ld_half};
				end
			end
			aluop_lw: begin
				mem_ce     = 1'b1;
				mem_addr_o = mem_addr_i;
				mem_sel_o  = 4'b1111;
				wdata_o    = mem_data_i;
			end
			aluop_lwl: begin
				mem_ce     = 1'b1;
				mem_addr_o = {mem_addr_i[word_w-1:2], 2'b00};
				mem_sel_o  = 4'b1111;
				// upper bytes from memory, low ones kept from reg2
				wdata_o = (mem_data_i << sh_l) | (reg2_i & ~({word_w{1'b1}} << sh_l));
			end
			aluop_lwr: begin
				mem_ce     = 1'b1;
				mem_addr_o = {mem_addr_i[word_w-1:2], 2'b00};
				mem_sel_o  = 4'b1111;
				wdata_o    = (mem_data_i >> sh_r) | (reg2_i & ~({word_w{1'b1}} >> sh_r));
			end
			aluop_sb: begin
				mem_ce     = 1'b1;
				mem_we     = 1'b1;
				mem_addr_o = mem_addr_i;
				mem_sel_o  = 4'b1000 >> ofs;
				mem_data_o = {4{reg2_i[7:0]}};
			end
			aluop_sh: begin
				mem_ce     = 1'b1;
				mem_we     = 1'b1;
				mem_addr_o = mem_addr_i;
				mem_data_o = {2{reg2_i[15:0]}};
				if (!ofs[0]) begin
					mem_sel_o = ofs[1] ? 4'b0011 : 4'b1100;
				end
			end
			aluop_sw: begin
				mem_ce     = 1'b1;
				mem_we     = 1'b1;
				mem_addr_o = mem_addr_i;
				mem_sel_o  = 4'b1111;
				mem_data_o = reg2_i;
			end
			aluop_swl: begin
				mem_ce     = 1'b1;
				mem_we     = 1'b1;
				mem_addr_o = {mem_addr_i[word_w-1:2], 2'b00};
				mem_sel_o  = 4'b1111 >> ofs;
				mem_data_o = reg2_i >> sh_l;
			end
			aluop_swr: begin
				mem_ce     = 1'b1;
				mem_we     = 1'b1;
				mem_addr_o = {mem_addr_i[word_w-1:2], 2'b00};
				mem_sel_o  = 4'b1111 << ~ofs;
				mem_data_o = reg2_i << sh_r;
			end
			default: begin
			end
		endcase
	end

	// newest CP0 values, a write sitting in writeback wins
	always_comb begin
		status_fwd = cp0_status_i;
		cause_fwd  = cp0_cause_i;
		epc_fwd    = cp0_epc_i;
		if (wb_cp0_we_i) begin
			case (wb_cp0_waddr_i)
				cp0_status_addr: status_fwd = wb_cp0_wdata_i;
				cp0_epc_addr:    epc_fwd = wb_cp0_wdata_i;
				cp0_cause_addr: begin
					cause_fwd[9:8]   = wb_cp0_wdata_i[9:8];	// IP1..0
					cause_fwd[23:22] = wb_cp0_wdata_i[23:22];	// IV, WP
				end
				default: begin
				end
			endcase
		end
	end

	always_comb begin
		exc_hit = 1'b1;
		exc_sel = exc_int;
		if (current_inst_address_i == '0) begin
			exc_hit = 1'b0;	// bubble
		end else if ((|(cause_fwd[15:8] & status_fwd[15:8])) &&
				!status_fwd[1] && status_fwd[0]) begin
			exc_sel = exc_int;
		end else if (excepttype_i[1]) begin
			exc_sel = exc_mod;
		end else if (excepttype_i[2]) begin
			exc_sel = exc_tlbl;
		end else if (excepttype_i[3]) begin
			exc_sel = exc_tlbs;
		end else if (excepttype_i[4]) begin
			exc_sel = exc_adel;
		end else if (excepttype_i[5]) begin
			exc_sel = exc_ades;
		end else if (excepttype_i[8]) begin
			exc_sel = exc_sys;
		end else if (excepttype_i[10]) begin
			exc_sel = exc_ri;
		end else if (excepttype_i[11]) begin
			exc_sel = exc_cpu;
		end else if (excepttype_i[12]) begin
			exc_sel = exc_ov;
		end else if (excepttype_i[23]) begin
			exc_sel = exc_watch;
		end else if (excepttype_i[14]) begin
			exc_sel = exc_eret;
		end else begin
			exc_hit = 1'b0;
		end
	end

	assign exc_valid_o = rst_n_i & exc_hit;
	assign exc_code_o  = exc_sel;
	assign mem_ce_o    = rst_n_i & mem_ce;
	assign mem_we_o    = rst_n_i & mem_we & ~exc_hit;	// cancel store on exception

endmodule

`default_nettype wire

// File: rtl/data_ram.sv
`timescale 1ns/1ns
`default_nettype none

module data_ram #(
	parameter int RAM_ADDR_W = 10
) (
	input  logic                        clk_i,
	input  logic                        ce_i,
	input  logic                        we_i,
	input  logic [3:0]                  sel_i,
	input  logic [mips_pkg::word_w-1:0] addr_i,
	input  logic [mips_pkg::word_w-1:0] data_i,
	output logic [mips_pkg::word_w-1:0] data_o
);
	import mips_pkg::*;

	logic [word_w-1:0]     mem [2**RAM_ADDR_W];
	logic [RAM_ADDR_W-1:0] idx;

	assign idx = addr_i[RAM_ADDR_W+1:2];	// word address

	always_ff @(posedge clk_i) begin
		if (ce_i && we_i) begin
			for (int i = 0; i < 4; i++) begin
				if (sel_i[i]) begin
					mem[idx][8*i +: 8] <= data_i[8*i +: 8];
				end
			end
		end
	end

	assign data_o = ce_i ? mem[idx] : '0;

endmodule

`default_nettype wire

// File: rtl/mips_pkg.sv
`default_nettype none

package mips_pkg;

	localparam int word_w     = 32;
	localparam int reg_addr_w = 5;

	// memory ops reuse the MIPS primary opcode
	typedef enum logic [7:0] {
		aluop_nop  = 8'h00,
		aluop_lb   = 8'h20,
		aluop_lh   = 8'h21,
		aluop_lwl  = 8'h22,
		aluop_lw   = 8'h23,
		aluop_lbu  = 8'h24,
		aluop_lhu  = 8'h25,
		aluop_lwr  = 8'h26,
		aluop_sb   = 8'h28,
		aluop_sh   = 8'h29,
		aluop_swl  = 8'h2a,
		aluop_sw   = 8'h2b,
		aluop_swr  = 8'h2e,
		aluop_mtc0 = 8'h60,
		aluop_eret = 8'h6b
	} aluop_e;

	typedef enum logic [4:0] {
		exc_int   = 5'd0,
		exc_mod   = 5'd1,
		exc_tlbl  = 5'd2,
		exc_tlbs  = 5'd3,
		exc_adel  = 5'd4,
		exc_ades  = 5'd5,
		exc_sys   = 5'd8,
		exc_ri    = 5'd10,
		exc_cpu   = 5'd11,
		exc_ov    = 5'd12,
		exc_eret  = 5'd14,	// internal, return from exception
		exc_watch = 5'd23
	} exc_code_e;

	localparam logic [4:0] cp0_status_addr = 5'd12;
	localparam logic [4:0] cp0_cause_addr  = 5'd13;
	localparam logic [4:0] cp0_epc_addr    = 5'd14;

endpackage

`default_nettype wire
